/* design/rv_idu_params.svh */
`ifndef RV_IDU_PARAMS_SVH
`define RV_IDU_PARAMS_SVH

// datapath and field widths.
`define XLEN       32
`define REG_ADDR_W 5
`define SEQ_W      16

//////////////////////////////////////////////////
// rv32i major opcodes, low two bits included.
//////////////////////////////////////////////////

`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_BRANCH   7'b1100011
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_OP_IMM   7'b0010011
`define OPC_OP       7'b0110011
`define OPC_MISC_MEM 7'b0001111
`define OPC_SYSTEM   7'b1110011

// funct7 values for the base and the alternate (sub, sra) encodings.
`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000

// system words are matched in full.
`define WORD_ECALL  32'h0000_0073
`define WORD_EBREAK 32'h0010_0073

`endif

/* design/rv_idu_pkg.sv */
`include "rv_idu_params.svh"

package rv_idu_pkg;

   typedef logic [`XLEN-1:0]       word_t;
   typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [`SEQ_W-1:0]      seq_t;

   //////////////////////////////////////////////////
   // decoded operation.
   //////////////////////////////////////////////////

   typedef enum logic [5:0] {
      OP_ILLEGAL,
      // upper immediates and jumps.
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
      // branches.
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
      // loads and stores.
      OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
      OP_SB, OP_SH, OP_SW,
      // register-immediate alu.
      OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
      OP_SLLI, OP_SRLI, OP_SRAI,
      // register-register alu.
      OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
      OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
      // ordering and environment.
      OP_FENCE, OP_ECALL, OP_EBREAK
   } op_e;

   // immediate layout of the word.
   typedef enum logic [2:0] {
      FMT_NONE,
      FMT_R,
      FMT_I,
      FMT_S,
      FMT_B,
      FMT_U,
      FMT_J
   } fmt_e;

endpackage

/* design/rv_opcode_decoder.sv */
`include "rv_idu_params.svh"

module rv_opcode_decoder import rv_idu_pkg::*; (
   input  word_t ifu_data,
   output op_e   dec_op,
   output fmt_e  dec_fmt,
   output logic  dec_rd_used,
   output logic  dec_rs1_used,
   output logic  dec_rs2_used
);

   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       no_regs;

   assign funct3 = ifu_data[14:12];
   assign funct7 = ifu_data[31:25];

   //////////////////////////////////////////////////
   // classification.
   //////////////////////////////////////////////////

   // every major opcode ends in 2'b11, so compressed words fall to default.
   always_comb begin
      dec_op = OP_ILLEGAL;
      case (ifu_data[6:0])
         `OPC_LUI:   dec_op = OP_LUI;
         `OPC_AUIPC: dec_op = OP_AUIPC;
         `OPC_JAL:   dec_op = OP_JAL;
         `OPC_JALR: begin
            if (funct3 == 3'b000) dec_op = OP_JALR;
         end
         `OPC_BRANCH: begin
            case (funct3)
               3'b000:  dec_op = OP_BEQ;
               3'b001:  dec_op = OP_BNE;
               3'b100:  dec_op = OP_BLT;
               3'b101:  dec_op = OP_BGE;
               3'b110:  dec_op = OP_BLTU;
               3'b111:  dec_op = OP_BGEU;
               default: dec_op = OP_ILLEGAL;
            endcase
         end
         `OPC_LOAD: begin
            case (funct3)
               3'b000:  dec_op = OP_LB;
               3'b001:  dec_op = OP_LH;
               3'b010:  dec_op = OP_LW;
               3'b100:  dec_op = OP_LBU;
               3'b101:  dec_op = OP_LHU;
               default: dec_op = OP_ILLEGAL;
            endcase
         end
         `OPC_STORE: begin
            case (funct3)
               3'b000:  dec_op = OP_SB;
               3'b001:  dec_op = OP_SH;
               3'b010:  dec_op = OP_SW;
               default: dec_op = OP_ILLEGAL;
            endcase
         end
         `OPC_OP_IMM: begin
            case (funct3)
               3'b000: dec_op = OP_ADDI;
               3'b010: dec_op = OP_SLTI;
               3'b011: dec_op = OP_SLTIU;
               3'b100: dec_op = OP_XORI;
               3'b110: dec_op = OP_ORI;
               3'b111: dec_op = OP_ANDI;
               // shift amounts sit in imm[4:0], so imm[11:5] acts as funct7.
               3'b001: begin
                  if (funct7 == `F7_BASE) dec_op = OP_SLLI;
               end
               default: begin
                  if (funct7 == `F7_BASE) dec_op = OP_SRLI;
                  else if (funct7 == `F7_ALT) dec_op = OP_SRAI;
               end
            endcase
         end
         `OPC_OP: begin
            if (funct7 == `F7_BASE) begin
               case (funct3)
                  3'b000:  dec_op = OP_ADD;
                  3'b001:  dec_op = OP_SLL;
                  3'b010:  dec_op = OP_SLT;
                  3'b011:  dec_op = OP_SLTU;
                  3'b100:  dec_op = OP_XOR;
                  3'b101:  dec_op = OP_SRL;
                  3'b110:  dec_op = OP_OR;
                  default: dec_op = OP_AND;
               endcase
            end else if (funct7 == `F7_ALT) begin
               if (funct3 == 3'b000) dec_op = OP_SUB;
               else if (funct3 == 3'b101) dec_op = OP_SRA;
            end
         end
         `OPC_MISC_MEM: begin
            if (funct3 == 3'b000) dec_op = OP_FENCE;
         end
         `OPC_SYSTEM: begin
            if (ifu_data == `WORD_ECALL) dec_op = OP_ECALL;
            else if (ifu_data == `WORD_EBREAK) dec_op = OP_EBREAK;
         end
         default: dec_op = OP_ILLEGAL;
      endcase
   end

   //////////////////////////////////////////////////
   // format and register use.
   //////////////////////////////////////////////////

   always_comb begin
      case (dec_op)
         OP_LUI, OP_AUIPC: dec_fmt = FMT_U;
         OP_JAL:           dec_fmt = FMT_J;
         OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: dec_fmt = FMT_B;
         OP_SB, OP_SH, OP_SW: dec_fmt = FMT_S;
         OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
         OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND: dec_fmt = FMT_R;
         OP_ILLEGAL: dec_fmt = FMT_NONE;
         default:    dec_fmt = FMT_I;
      endcase
   end

   // fence and the system words carry no register operands.
   assign no_regs = dec_op inside {OP_FENCE, OP_ECALL, OP_EBREAK};

   assign dec_rd_used  = !no_regs && (dec_fmt inside {FMT_R, FMT_I, FMT_U, FMT_J});
   assign dec_rs1_used = !no_regs && (dec_fmt inside {FMT_R, FMT_I, FMT_S, FMT_B});
   assign dec_rs2_used = dec_fmt inside {FMT_R, FMT_S, FMT_B};

endmodule

/* design/rv_decode_stage.sv */
module rv_decode_stage import rv_idu_pkg::*; (
   input  logic  clock,
   input  logic  reset,
   input  logic  ifu_vld,
   input  word_t ifu_addr,
   input  word_t ifu_data,
   input  op_e   dec_op,
   input  fmt_e  dec_fmt,
   input  logic  dec_rd_used,
   input  logic  dec_rs1_used,
   input  logic  dec_rs2_used,
   output logic  idu_vld,
   output seq_t  idu_seq,
   output word_t idu_addr,
   output word_t idu_data,
   output op_e   idu_op,
   output fmt_e  stg_fmt,
   output logic  idu_rd_used,
   output logic  idu_rs1_used,
   output logic  idu_rs2_used
);

   // valid strobe and sequence counter.
   // the counter doubles as the output tag, so the first strobe shows 1.
   always_ff @(posedge clock) begin
      if (reset) begin
         idu_vld <= 1'b0;
         idu_seq <= '0;
      end else begin
         idu_vld <= ifu_vld;
         if (ifu_vld) begin
            idu_seq <= idu_seq + seq_t'(1);
         end
      end
   end

   // decoded record, held between strobes.
   always_ff @(posedge clock) begin
      if (ifu_vld) begin
         idu_addr     <= ifu_addr;
         idu_data     <= ifu_data;
         idu_op       <= dec_op;
         stg_fmt      <= dec_fmt;
         idu_rd_used  <= dec_rd_used;
         idu_rs1_used <= dec_rs1_used;
         idu_rs2_used <= dec_rs2_used;
      end
   end

endmodule

/* design/rv_operand_extract.sv */
module rv_operand_extract import rv_idu_pkg::*; (
   input  word_t     idu_data,
   input  fmt_e      stg_fmt,
   input  logic      idu_rd_used,
   input  logic      idu_rs1_used,
   input  logic      idu_rs2_used,
   output reg_addr_t idu_rd,
   output reg_addr_t idu_rs1,
   output reg_addr_t idu_rs2,
   output word_t     idu_immed
);

   word_t immed_i;
   word_t immed_s;
   word_t immed_b;
   word_t immed_u;
   word_t immed_j;

   //////////////////////////////////////////////////
   // register fields.
   //////////////////////////////////////////////////

   assign idu_rd  = idu_rd_used  ? idu_data[11:7]  : '0;
   assign idu_rs1 = idu_rs1_used ? idu_data[19:15] : '0;
   assign idu_rs2 = idu_rs2_used ? idu_data[24:20] : '0;

   //////////////////////////////////////////////////
   // immediates, sign taken from bit 31.
   //////////////////////////////////////////////////

   assign immed_i = {{20{idu_data[31]}}, idu_data[31:20]};
   assign immed_s = {{20{idu_data[31]}}, idu_data[31:25], idu_data[11:7]};
   assign immed_b = {{19{idu_data[31]}}, idu_data[31], idu_data[7],
                     idu_data[30:25], idu_data[11:8], 1'b0};
   assign immed_u = {idu_data[31:12], 12'd0};
   assign immed_j = {{11{idu_data[31]}}, idu_data[31], idu_data[19:12],
                     idu_data[20], idu_data[30:21], 1'b0};

   always_comb begin
      case (stg_fmt)
         FMT_I:   idu_immed = immed_i;
         FMT_S:   idu_immed = immed_s;
         FMT_B:   idu_immed = immed_b;
         FMT_U:   idu_immed = immed_u;
         FMT_J:   idu_immed = immed_j;
         // r-format and illegal words carry no immediate.
         default: idu_immed = '0;
      endcase
   end

endmodule

/* design/rv_idu.sv */
module rv_idu import rv_idu_pkg::*; (
   input  logic      clock,
   input  logic      reset,
   input  logic      ifu_vld,
   input  word_t     ifu_addr,
   input  word_t     ifu_data,
   output logic      idu_vld,
   output seq_t      idu_seq,
   output word_t     idu_addr,
   output word_t     idu_data,
   output op_e       idu_op,
   output reg_addr_t idu_rd,
   output reg_addr_t idu_rs1,
   output reg_addr_t idu_rs2,
   output logic      idu_rd_used,
   output logic      idu_rs1_used,
   output logic      idu_rs2_used,
   output word_t     idu_immed
);

   op_e  dec_op;
   fmt_e dec_fmt;
   fmt_e stg_fmt;
   logic dec_rd_used;
   logic dec_rs1_used;
   logic dec_rs2_used;

   rv_opcode_decoder decoder0 (
      .ifu_data     (ifu_data),
      .dec_op       (dec_op),
      .dec_fmt      (dec_fmt),
      .dec_rd_used  (dec_rd_used),
      .dec_rs1_used (dec_rs1_used),
      .dec_rs2_used (dec_rs2_used)
   );

   rv_decode_stage stage0 (
      .clock        (clock),
      .reset        (reset),
      .ifu_vld      (ifu_vld),
      .ifu_addr     (ifu_addr),
      .ifu_data     (ifu_data),
      .dec_op       (dec_op),
      .dec_fmt      (dec_fmt),
      .dec_rd_used  (dec_rd_used),
      .dec_rs1_used (dec_rs1_used),
      .dec_rs2_used (dec_rs2_used),
      .idu_vld      (idu_vld),
      .idu_seq      (idu_seq),
      .idu_addr     (idu_addr),
      .idu_data     (idu_data),
      .idu_op       (idu_op),
      .stg_fmt      (stg_fmt),
      .idu_rd_used  (idu_rd_used),
      .idu_rs1_used (idu_rs1_used),
      .idu_rs2_used (idu_rs2_used)
   );

   // works on the registered word.
   rv_operand_extract extract0 (
      .idu_data     (idu_data),
      .stg_fmt      (stg_fmt),
      .idu_rd_used  (idu_rd_used),
      .idu_rs1_used (idu_rs1_used),
      .idu_rs2_used (idu_rs2_used),
      .idu_rd       (idu_rd),
      .idu_rs1      (idu_rs1),
      .idu_rs2      (idu_rs2),
      .idu_immed    (idu_immed)
   );

endmodule

/* tests/rv_idu_chk.sv */
module rv_idu_chk import rv_idu_pkg::*; (
   input logic clock,
   input logic reset,
   input logic ifu_vld,
   input logic idu_vld,
   input seq_t idu_seq,
   input op_e  idu_op,
   input logic idu_rd_used,
   input logic idu_rs1_used,
   input logic idu_rs2_used
);

   // every strobe is answered in the next cycle.
   strobe_answered: assert property (@(posedge clock) disable iff (reset)
      ifu_vld |=> idu_vld)
      else $error("idu_vld missing in the cycle after a strobe");

   no_spurious_valid: assert property (@(posedge clock) disable iff (reset)
      idu_vld |-> $past(ifu_vld))
      else $error("idu_vld high without a strobe in the previous cycle");

   // the tag only moves with a new valid output.
   seq_step: assert property (@(posedge clock) disable iff (reset)
      idu_vld |-> idu_seq == $past(idu_seq) + seq_t'(1))
      else $error("idu_seq did not advance by one");

   illegal_no_regs: assert property (@(posedge clock) disable iff (reset)
      (idu_vld && idu_op == OP_ILLEGAL) |-> !(idu_rd_used || idu_rs1_used || idu_rs2_used))
      else $error("illegal instruction reports a used register");

endmodule

/* tests/rv_idu_tb.sv */
`include "rv_idu_params.svh"

module rv_idu_tb import rv_idu_pkg::*; ();

   typedef struct packed {
      op_e       op;
      logic      rd_used;
      logic      rs1_used;
      logic      rs2_used;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      word_t     immed;
      word_t     addr;
      word_t     data;
   } expected_t;

   localparam int b2b_cycles = 200;
   localparam int mix_cycles = 600;
   localparam int ill_cycles = 300;
   localparam int run_cycles = 4 + (b2b_cycles + 1) + (mix_cycles + 1) + (ill_cycles + 1);

   // rows indexed by funct3.
   localparam op_e branch_ops [8] = '{OP_BEQ, OP_BNE, OP_ILLEGAL, OP_ILLEGAL,
                                      OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
   localparam op_e load_ops [8] = '{OP_LB, OP_LH, OP_LW, OP_ILLEGAL,
                                    OP_LBU, OP_LHU, OP_ILLEGAL, OP_ILLEGAL};
   localparam op_e store_ops [8] = '{OP_SB, OP_SH, OP_SW, OP_ILLEGAL,
                                     OP_ILLEGAL, OP_ILLEGAL, OP_ILLEGAL, OP_ILLEGAL};
   localparam op_e imm_ops [8] = '{OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU,
                                   OP_XORI, OP_SRLI, OP_ORI, OP_ANDI};
   localparam op_e reg_ops [8] = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU,
                                   OP_XOR, OP_SRL, OP_OR, OP_AND};
   localparam op_e alt_ops [8] = '{OP_SUB, OP_ILLEGAL, OP_ILLEGAL, OP_ILLEGAL,
                                   OP_ILLEGAL, OP_SRA, OP_ILLEGAL, OP_ILLEGAL};
   // weighted toward the classes with many funct3 values.
   localparam logic [6:0] opc_pool [16] = '{`OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR,
      `OPC_BRANCH, `OPC_LOAD, `OPC_STORE, `OPC_OP_IMM, `OPC_OP, `OPC_MISC_MEM,
      `OPC_SYSTEM, `OPC_OP_IMM, `OPC_OP, `OPC_BRANCH, `OPC_LOAD, `OPC_STORE};

   logic      clock;
   logic      reset;
   logic      ifu_vld;
   word_t     ifu_addr;
   word_t     ifu_data;
   logic      idu_vld;
   seq_t      idu_seq;
   word_t     idu_addr;
   word_t     idu_data;
   op_e       idu_op;
   reg_addr_t idu_rd;
   reg_addr_t idu_rs1;
   reg_addr_t idu_rs2;
   logic      idu_rd_used;
   logic      idu_rs1_used;
   logic      idu_rs2_used;
   word_t     idu_immed;

   logic [31:0] lfsr_state = 32'h69c3;
   expected_t   exp_q [$];
   expected_t   last;
   logic        have_last = 1'b0;
   seq_t        seq_model = '0;
   int          test_errors = 0;
   int          pass_count = 0;
   int          fail_count = 0;

   rv_idu dut0 (.*);

   bind rv_idu rv_idu_chk chk0 (
      .clock        (clock),
      .reset        (reset),
      .ifu_vld      (ifu_vld),
      .idu_vld      (idu_vld),
      .idu_seq      (idu_seq),
      .idu_op       (idu_op),
      .idu_rd_used  (idu_rd_used),
      .idu_rs1_used (idu_rs1_used),
      .idu_rs2_used (idu_rs2_used)
   );

   initial begin
      clock = 1'b0;
      forever #50 clock = ~clock;
   end

   //////////////////////////////////////////////////
   // random source and stimulus.
   //////////////////////////////////////////////////

   function automatic logic next_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
      return v;
   endfunction

   // kind 0 is a legal template, 1 a funct variant, 2 a raw word.
   function automatic word_t make_word(input int kind);
      word_t       w;
      logic [31:0] r;
      logic [6:0]  opc;
      w = rand_bits(32);
      r = rand_bits(4);
      opc = opc_pool[r[3:0]];
      if (kind == 2) return w;
      w[6:0] = opc;
      r = rand_bits(2);
      if (kind == 1) begin
         // 7'b0000001 is the multiply/divide group.
         case (r[1:0])
            2'd0:    w[31:25] = `F7_BASE;
            2'd1:    w[31:25] = `F7_ALT;
            2'd2:    w[31:25] = 7'b0000001;
            default: ;
         endcase
         return w;
      end
      case (opc)
         `OPC_JALR, `OPC_MISC_MEM: w[14:12] = 3'b000;
         `OPC_BRANCH: if (w[14:13] == 2'b01) w[13] = 1'b0;
         `OPC_LOAD: if (w[14:12] inside {3'd3, 3'd6, 3'd7}) w[14:12] = 3'd2;
         `OPC_STORE: begin
            w[14] = 1'b0;
            if (w[13:12] == 2'b11) w[12] = 1'b0;
         end
         `OPC_OP_IMM: begin
            if (w[14:12] == 3'd1) w[31:25] = `F7_BASE;
            if (w[14:12] == 3'd5) w[31:25] = r[0] ? `F7_ALT : `F7_BASE;
         end
         `OPC_OP: w[31:25] = (r[0] && (w[14:12] == 3'd0 || w[14:12] == 3'd5)) ?
                             `F7_ALT : `F7_BASE;
         `OPC_SYSTEM: w = r[0] ? `WORD_EBREAK : `WORD_ECALL;
         default: ;
      endcase
      return w;
   endfunction

   //////////////////////////////////////////////////
   // reference decode.
   //////////////////////////////////////////////////

   function automatic expected_t model_decode(input word_t w, input word_t a);
      expected_t  e;
      fmt_e       fmt;
      logic       no_regs;
      logic [2:0] f3;
      logic [6:0] f7;
      f3 = w[14:12];
      f7 = w[31:25];
      case (w[6:0])
         `OPC_LUI:      e.op = OP_LUI;
         `OPC_AUIPC:    e.op = OP_AUIPC;
         `OPC_JAL:      e.op = OP_JAL;
         `OPC_JALR:     e.op = (f3 == 3'd0) ? OP_JALR : OP_ILLEGAL;
         `OPC_BRANCH:   e.op = branch_ops[f3];
         `OPC_LOAD:     e.op = load_ops[f3];
         `OPC_STORE:    e.op = store_ops[f3];
         `OPC_OP_IMM:   e.op = imm_ops[f3];
         `OPC_OP:       e.op = (f7 == `F7_BASE) ? reg_ops[f3] : alt_ops[f3];
         `OPC_MISC_MEM: e.op = (f3 == 3'd0) ? OP_FENCE : OP_ILLEGAL;
         `OPC_SYSTEM:   e.op = (w == `WORD_ECALL) ? OP_ECALL :
                               (w == `WORD_EBREAK) ? OP_EBREAK : OP_ILLEGAL;
         default:       e.op = OP_ILLEGAL;
      endcase
      if (w[6:0] == `OPC_OP && !(f7 inside {`F7_BASE, `F7_ALT})) e.op = OP_ILLEGAL;
      if (w[6:0] == `OPC_OP_IMM && f3 == 3'd1 && f7 != `F7_BASE) e.op = OP_ILLEGAL;
      if (w[6:0] == `OPC_OP_IMM && f3 == 3'd5) begin
         if (f7 == `F7_ALT) e.op = OP_SRAI;
         else if (f7 != `F7_BASE) e.op = OP_ILLEGAL;
      end
      case (w[6:0])
         `OPC_LUI, `OPC_AUIPC: fmt = FMT_U;
         `OPC_JAL:             fmt = FMT_J;
         `OPC_BRANCH:          fmt = FMT_B;
         `OPC_STORE:           fmt = FMT_S;
         `OPC_OP:              fmt = FMT_R;
         default:              fmt = FMT_I;
      endcase
      if (e.op == OP_ILLEGAL) fmt = FMT_NONE;
      no_regs = (e.op == OP_FENCE) || (e.op == OP_ECALL) || (e.op == OP_EBREAK);
      e.rd_used  = !no_regs && (fmt inside {FMT_R, FMT_I, FMT_U, FMT_J});
      e.rs1_used = !no_regs && (fmt inside {FMT_R, FMT_I, FMT_S, FMT_B});
      e.rs2_used = fmt inside {FMT_R, FMT_S, FMT_B};
      e.rd  = e.rd_used  ? w[11:7]  : 5'd0;
      e.rs1 = e.rs1_used ? w[19:15] : 5'd0;
      e.rs2 = e.rs2_used ? w[24:20] : 5'd0;
      case (fmt)
         FMT_I:   e.immed = {{20{w[31]}}, w[31:20]};
         FMT_S:   e.immed = {{21{w[31]}}, w[30:25], w[11:7]};
         FMT_B:   e.immed = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         FMT_U:   e.immed = {w[31:12], 12'h000};
         FMT_J:   e.immed = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         default: e.immed = '0;
      endcase
      e.addr = a;
      e.data = w;
      return e;
   endfunction

   //////////////////////////////////////////////////
   // checks and test flow.
   //////////////////////////////////////////////////

   function automatic void check_field(input string name, input logic [31:0] got,
                                       input logic [31:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
         test_errors++;
      end
   endfunction

   function automatic void compare_record(input expected_t e);
      check_field("idu_op", 32'(idu_op), 32'(e.op));
      check_field("idu_rd_used", 32'(idu_rd_used), 32'(e.rd_used));
      check_field("idu_rs1_used", 32'(idu_rs1_used), 32'(e.rs1_used));
      check_field("idu_rs2_used", 32'(idu_rs2_used), 32'(e.rs2_used));
      check_field("idu_rd", 32'(idu_rd), 32'(e.rd));
      check_field("idu_rs1", 32'(idu_rs1), 32'(e.rs1));
      check_field("idu_rs2", 32'(idu_rs2), 32'(e.rs2));
      check_field("idu_immed", idu_immed, e.immed);
      check_field("idu_addr", idu_addr, e.addr);
      check_field("idu_data", idu_data, e.data);
   endfunction

   // outputs are checked before the next inputs are driven.
   task automatic step(input logic vld, input word_t w, input word_t a);
      @(posedge clock);
      #10;
      check_field("idu_vld", 32'(idu_vld), 32'(exp_q.size() == 1));
      if (exp_q.size() > 0) begin
         last = exp_q.pop_front();
         have_last = 1'b1;
         seq_model++;
      end
      if (have_last) compare_record(last);
      check_field("idu_seq", 32'(idu_seq), 32'(seq_model));
      ifu_vld = vld;
      ifu_data = w;
      ifu_addr = a;
      if (vld) exp_q.push_back(model_decode(w, a));
   endtask

   task automatic report_test(input string name);
      if (test_errors == 0) begin
         pass_count++;
         $display("test %s: ok", name);
      end else begin
         fail_count++;
         $display("test %s: %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic run_test(input string name, input int cycles, input int mix);
      word_t       w;
      word_t       a;
      logic [31:0] r;
      logic        vld;
      int          kind;
      for (int i = 0; i < cycles; i++) begin
         r = rand_bits(2);
         vld = (mix == 0) || (r[1:0] != 2'b00);
         r = rand_bits(2);
         if (mix == 0) kind = 0;
         else if (mix == 2) kind = r[0] ? 1 : 2;
         else kind = r[1] ? (r[0] ? 2 : 1) : 0;
         w = make_word(kind);
         a = rand_bits(32);
         a[1:0] = 2'b00;
         step(vld, w, a);
      end
      // one idle cycle so the last strobe is checked.
      step(1'b0, '0, '0);
      report_test(name);
   endtask

   initial begin
      reset = 1'b1;
      ifu_vld = 1'b0;
      ifu_addr = '0;
      ifu_data = '0;
      repeat (3) step(1'b0, '0, '0);
      reset = 1'b0;
      step(1'b0, '0, '0);
      report_test("reset");
      run_test("back_to_back", b2b_cycles, 0);
      run_test("random_stream", mix_cycles, 1);
      run_test("illegal_words", ill_cycles, 2);
      $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      #(2 * run_cycles * 100 + 3 * 100);
      $display("timeout: the decode tests did not finish in time");
      $display("Test failures found");
      $finish;
   end

endmodule

/* build.f */
+incdir+design
design/rv_idu_pkg.sv
design/rv_opcode_decoder.sv
design/rv_decode_stage.sv
design/rv_operand_extract.sv
design/rv_idu.sv
tests/rv_idu_chk.sv
tests/rv_idu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module rv_idu_tb -Mdir obj_dir
out=$(./obj_dir/Vrv_idu_tb) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qF 'All tests passed!'; then
   exit 0
fi
exit 1
